// ==== Bender.yml ====
package:
  name: apogeo_datapath

sources:
  - files:
      - src/apogeo_pkg.sv
      - src/apogeo_if.sv
      - src/register_file.sv
      - src/operand_fetch.sv
      - src/execute_unit.sv
      - src/apogeo_datapath.sv
  - target: test
    files:
      - test/tb_apogeo_datapath.sv

// ==== src/apogeo_datapath.sv ====
module apogeo_datapath #(
    parameter bit HAS_FPU = 1'b1  // Build the float banks and decode FP ops.
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Instruction in, one per cycle at most.
    input  logic                  instr_valid_i,
    input  apogeo_pkg::instr_t    instr_i,

    // Writeback result, valid for one cycle.
    output logic                  result_valid_o,
    output apogeo_pkg::reg_addr_t result_rd_o,
    output logic                  result_is_float_o,
    output apogeo_pkg::data_t     result_data_o
);

    issue_if   issue ();   // Fetch to execute.
    result_if  ex_fwd ();  // Execute stage bypass.
    result_if  wb ();      // Result register.
    rf_read_if rf_rd ();   // Operand reads.

    operand_fetch #(
        .HAS_FPU (HAS_FPU)
    ) operand_fetch_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rf            (rf_rd),
        .ex_fwd        (ex_fwd),
        .wb            (wb),
        .issue         (issue)
    );

    execute_unit execute_unit_i (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .issue  (issue),
        .ex_fwd (ex_fwd),
        .wb     (wb)
    );

    register_file #(
        .HAS_FPU (HAS_FPU)
    ) register_file_i (
        .clk_i   (clk_i),
        .rd_port (rf_rd),
        .wr_port (wb)
    );

    // Outputs mirror the write port.
    assign result_valid_o    = wb.valid;
    assign result_rd_o       = wb.rd;
    assign result_is_float_o = wb.rd_is_float;
    assign result_data_o     = wb.data;

endmodule : apogeo_datapath

// ==== src/apogeo_if.sv ====
// Issue slot from operand fetch into execute.
interface issue_if;

    logic                  valid;        // Slot holds a supported instruction.
    apogeo_pkg::alu_op_e   op;
    apogeo_pkg::data_t     operand_a;    // Resolved rs1.
    apogeo_pkg::data_t     operand_b;    // Resolved rs2 or immediate.
    apogeo_pkg::reg_addr_t rd;
    logic                  rd_is_float;  // Destination class.

    modport issue_src (
        output valid, op, operand_a, operand_b, rd, rd_is_float
    );

    modport issue_dst (
        input valid, op, operand_a, operand_b, rd, rd_is_float
    );

endinterface : issue_if


// A result on its way back, used for forwarding and for the write port.
interface result_if;

    logic                  valid;
    apogeo_pkg::reg_addr_t rd;
    logic                  rd_is_float;
    apogeo_pkg::data_t     data;

    modport res_src   (output valid, rd, rd_is_float, data);
    modport res_snoop (input valid, rd, rd_is_float, data);  // Bypass compare.
    modport res_write (input valid, rd, rd_is_float, data);  // Register file write.

endinterface : result_if


// Two read ports of the register file, indexed 1 and 2 like rs1 and rs2.
interface rf_read_if;

    apogeo_pkg::reg_addr_t [2:1] read_address;
    logic                  [2:1] src_is_float;  // Pick the float bank per port.
    apogeo_pkg::data_t     [2:1] read_data;

    modport reader (
        output read_address, src_is_float,
        input  read_data
    );

    modport bank (
        input  read_address, src_is_float,
        output read_data
    );

endinterface : rf_read_if

// ==== src/apogeo_pkg.sv ====
package apogeo_pkg;

    // ################################################
    // Widths.
    // ################################################

    typedef logic [31:0] data_t;      // One register word.
    typedef logic [4:0]  reg_addr_t;  // Register index, x0..x31 or f0..f31.
    typedef logic [31:0] instr_t;     // Raw instruction word.

    // ################################################
    // Operations seen by the execute unit.
    // ################################################

    typedef enum logic [3:0] {
        OP_ADD,     // Integer add, also ADDI.
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_FSGNJ,   // Sign from operand b.
        OP_FSGNJN,  // Inverted sign of operand b.
        OP_FSGNJX,  // XOR of both signs.
        OP_MOVE     // Operand a passes through, both FMV flavours.
    } alu_op_e;

    // ################################################
    // Encodings.
    // ################################################

    // Major opcodes, instruction bits 6:0.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP_FP  = 7'b1010011;

    // Funct7 of the single precision ops we handle.
    localparam logic [6:0] F7_FSGNJ   = 7'b0010000;  // FSGNJ, FSGNJN, FSGNJX.
    localparam logic [6:0] F7_FMV_X_W = 7'b1110000;  // Float bits to integer reg.
    localparam logic [6:0] F7_FMV_W_X = 7'b1111000;  // Integer bits to float reg.

endpackage : apogeo_pkg

// ==== src/execute_unit.sv ====
module execute_unit (
    input logic clk_i,
    input logic rst_i,

    issue_if.issue_dst issue,   // Operands from fetch.
    result_if.res_src  ex_fwd,  // Combinational result, same cycle.
    result_if.res_src  wb       // Registered result, drives the write port.
);

    // ################################################
    // Result logic.
    // ################################################

    apogeo_pkg::data_t result;
    logic              sign_a;  // Operand signs for sign injection.
    logic              sign_b;

    assign sign_a = issue.operand_a[31];
    assign sign_b = issue.operand_b[31];

    always_comb begin
        case (issue.op)
            apogeo_pkg::OP_ADD: begin
                result = issue.operand_a + issue.operand_b;  // Wraps at 32 bits.
            end
            apogeo_pkg::OP_SUB: begin
                result = issue.operand_a - issue.operand_b;
            end
            apogeo_pkg::OP_AND: begin
                result = issue.operand_a & issue.operand_b;
            end
            apogeo_pkg::OP_OR: begin
                result = issue.operand_a | issue.operand_b;
            end
            apogeo_pkg::OP_XOR: begin
                result = issue.operand_a ^ issue.operand_b;
            end

            // Magnitude always from a.
            apogeo_pkg::OP_FSGNJ: begin
                result = {sign_b, issue.operand_a[30:0]};
            end
            apogeo_pkg::OP_FSGNJN: begin
                result = {~sign_b, issue.operand_a[30:0]};
            end
            apogeo_pkg::OP_FSGNJX: begin
                result = {sign_a ^ sign_b, issue.operand_a[30:0]};
            end

            default: begin
                result = issue.operand_a;  // OP_MOVE, raw bits across classes.
            end
        endcase
    end

    // Bypass view of the instruction in this stage.
    assign ex_fwd.valid       = issue.valid;
    assign ex_fwd.rd          = issue.rd;
    assign ex_fwd.rd_is_float = issue.rd_is_float;
    assign ex_fwd.data        = result;

    // ################################################
    // Result register.
    // ################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= issue.valid;
        end
    end

    // Payload follows the slot every cycle.
    always_ff @(posedge clk_i) begin
        wb.rd          <= issue.rd;
        wb.rd_is_float <= issue.rd_is_float;
        wb.data        <= result;
    end

endmodule : execute_unit

// ==== src/operand_fetch.sv ====
module operand_fetch #(
    parameter bit HAS_FPU = 1'b1
) (
    input logic               clk_i,
    input logic               rst_i,
    input logic               instr_valid_i,
    input apogeo_pkg::instr_t instr_i,

    rf_read_if.reader  rf,      // Register file read ports.
    result_if.res_snoop ex_fwd, // Instruction in execute.
    result_if.res_snoop wb,     // Result register, one step older.
    issue_if.issue_src issue    // Slot into execute.
);

    // Funct fields local to this decoder.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_SGNJ    = 3'b000;
    localparam logic [2:0] F3_SGNJN   = 3'b001;
    localparam logic [2:0] F3_SGNJX   = 3'b010;
    localparam logic [2:0] F3_FMV     = 3'b000;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // ################################################
    // Instruction register.
    // ################################################

    logic               instr_valid_q;
    apogeo_pkg::instr_t instr_q;  // Payload, no reset.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        instr_q <= instr_i;
    end

    // ################################################
    // Decode.
    // ################################################

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    apogeo_pkg::reg_addr_t [2:1] src_addr;
    apogeo_pkg::data_t     imm;        // Sign extended I-type immediate.

    assign opcode      = instr_q[6:0];
    assign funct3      = instr_q[14:12];
    assign funct7      = instr_q[31:25];
    assign src_addr[1] = instr_q[19:15];
    assign src_addr[2] = instr_q[24:20];
    assign imm         = {{20{instr_q[31]}}, instr_q[31:20]};

    logic                supported;
    apogeo_pkg::alu_op_e op;
    logic [2:1]          src_float;  // Source classes.
    logic                rd_float;   // Destination class.
    logic                use_imm;

    always_comb begin
        supported = 1'b0;
        op        = apogeo_pkg::OP_ADD;
        src_float = 2'b00;
        rd_float  = 1'b0;
        use_imm   = 1'b0;

        case (opcode)
            apogeo_pkg::OPC_OP: begin
                supported = 1'b1;
                if (funct7 == F7_BASE && funct3 == F3_ADD_SUB) op = apogeo_pkg::OP_ADD;
                else if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) op = apogeo_pkg::OP_SUB;
                else if (funct7 == F7_BASE && funct3 == F3_XOR) op = apogeo_pkg::OP_XOR;
                else if (funct7 == F7_BASE && funct3 == F3_OR) op = apogeo_pkg::OP_OR;
                else if (funct7 == F7_BASE && funct3 == F3_AND) op = apogeo_pkg::OP_AND;
                else supported = 1'b0;  // Shifts, compares, M extension.
            end

            apogeo_pkg::OPC_OP_IMM: begin
                supported = (funct3 == F3_ADD_SUB);  // ADDI only.
                use_imm   = 1'b1;
            end

            apogeo_pkg::OPC_OP_FP: begin
                // The rs2 field of the moves is not checked.
                if (HAS_FPU) begin
                    if (funct7 == apogeo_pkg::F7_FSGNJ) begin
                        supported = 1'b1;
                        src_float = 2'b11;
                        rd_float  = 1'b1;
                        case (funct3)
                            F3_SGNJ:  op = apogeo_pkg::OP_FSGNJ;
                            F3_SGNJN: op = apogeo_pkg::OP_FSGNJN;
                            F3_SGNJX: op = apogeo_pkg::OP_FSGNJX;
                            default:  supported = 1'b0;
                        endcase
                    end else if (funct7 == apogeo_pkg::F7_FMV_X_W) begin
                        supported = (funct3 == F3_FMV);
                        op        = apogeo_pkg::OP_MOVE;
                        src_float = 2'b01;  // Float in, integer out.
                    end else if (funct7 == apogeo_pkg::F7_FMV_W_X) begin
                        supported = (funct3 == F3_FMV);
                        op        = apogeo_pkg::OP_MOVE;
                        rd_float  = 1'b1;   // Integer in, float out.
                    end
                end
            end

            default: ;  // Anything else produces no result.
        endcase
    end

    assign rf.read_address = src_addr;
    assign rf.src_is_float = src_float;

    // ################################################
    // Forwarding.
    // ################################################

    apogeo_pkg::data_t [2:1] operand;

    for (genvar s = 1; s <= 2; s++) begin : g_src
        logic is_x0;   // Integer x0, hardwired zero.
        logic ex_hit;  // Youngest producer wins.
        logic wb_hit;

        assign is_x0  = !src_float[s] && (src_addr[s] == '0);
        assign ex_hit = ex_fwd.valid && (ex_fwd.rd == src_addr[s])
                     && (ex_fwd.rd_is_float == src_float[s]);
        assign wb_hit = wb.valid && (wb.rd == src_addr[s])
                     && (wb.rd_is_float == src_float[s]);

        assign operand[s] = is_x0  ? '0
                          : ex_hit ? ex_fwd.data
                          : wb_hit ? wb.data
                          : rf.read_data[s];
    end

    // ################################################
    // Issue slot.
    // ################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= instr_valid_q && supported;
        end
    end

    always_ff @(posedge clk_i) begin
        issue.op          <= op;
        issue.operand_a   <= operand[1];
        issue.operand_b   <= use_imm ? imm : operand[2];
        issue.rd          <= instr_q[11:7];
        issue.rd_is_float <= rd_float;
    end

endmodule : operand_fetch

// ==== src/register_file.sv ====
module register_file #(
    parameter bit HAS_FPU = 1'b1
) (
    input logic clk_i,

    rf_read_if.bank     rd_port,  // Two combinational read ports.
    result_if.res_write wr_port   // Writeback from the result register.
);

    // ################################################
    // Write enables.
    // ################################################

    logic       wr_int;    // Write lands in the integer banks.
    logic       wr_fp;     // Write lands in the float banks.
    logic [2:1] rd_float;  // Per port bank select.

    // Without an FPU everything is an integer access.
    assign wr_int = wr_port.valid && !(HAS_FPU && wr_port.rd_is_float);
    assign wr_fp  = wr_port.valid && HAS_FPU && wr_port.rd_is_float;

    // ################################################
    // Banks, one copy per read port.
    // ################################################

    // Each read port owns a full copy of every bank.
    // All copies see the same write, so they never diverge.
    for (genvar p = 1; p <= 2; p++) begin : g_port

        apogeo_pkg::data_t int_bank [32];  // Integer copy for this port.
        apogeo_pkg::data_t int_data;
        apogeo_pkg::data_t fp_data;

        always_ff @(posedge clk_i) begin
            if (wr_int) begin
                int_bank[wr_port.rd] <= wr_port.data;  // x0 is stored, never read.
            end
        end

        // x0 is hardwired to zero on the read side.
        assign int_data = (rd_port.read_address[p] == '0) ? '0
                        : int_bank[rd_port.read_address[p]];

        if (HAS_FPU) begin : g_fp

            apogeo_pkg::data_t fp_bank [32];  // f0 is a real register.

            always_ff @(posedge clk_i) begin
                if (wr_fp) begin
                    fp_bank[wr_port.rd] <= wr_port.data;
                end
            end

            assign fp_data = fp_bank[rd_port.read_address[p]];

        end else begin : g_no_fp

            assign fp_data = '0;  // Never selected.

        end

        // Output mux.
        assign rd_float[p]             = HAS_FPU && rd_port.src_is_float[p];
        assign rd_port.read_data[p]    = rd_float[p] ? fp_data : int_data;

    end

endmodule : register_file

// ==== tb.f ====
src/apogeo_pkg.sv
src/apogeo_if.sv
src/register_file.sv
src/operand_fetch.sv
src/execute_unit.sv
src/apogeo_datapath.sv
test/tb_apogeo_datapath.sv

// ==== test/tb_apogeo_datapath.sv ====
module tb_apogeo_datapath;

    localparam logic [6:0] OPC_OP  = 7'h33;  // Integer register ops.
    localparam logic [6:0] OPC_IMM = 7'h13;
    localparam logic [6:0] OPC_FP  = 7'h53;

    logic        clk_i;
    logic        rst_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        result_valid_o;
    logic [4:0]  result_rd_o;
    logic        result_is_float_o;
    logic [31:0] result_data_o;

    apogeo_datapath #(.HAS_FPU(1'b1)) apogeo_datapath_i (.*);

    always #4 clk_i = ~clk_i;  // Period 8.

    // ################################################
    // Reference model and bookkeeping.
    // ################################################

    logic [31:0] int_model [32];  // Entry 0 stays zero.
    logic [31:0] fp_model  [32];
    logic [37:0] exp_q [$];       // {is_float, rd, data} in program order.
    logic [31:0] rng_state = 32'h79ef_ffa4;
    string       current_test = "reset";
    int          error_count, test_errors, check_count, tests_run, tests_failed;
    int          results_seen, supported_sent;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Decodes by the ISA rules and updates the model in program order.
    function automatic logic ref_exec(input logic [31:0] ins, output logic [37:0] res);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a, b, fa, fb, v;
        logic        ok, to_fp;
        f7 = ins[31:25];
        f3 = ins[14:12];
        rd = ins[11:7];
        a  = int_model[ins[19:15]];
        b  = int_model[ins[24:20]];
        fa = fp_model[ins[19:15]];
        fb = fp_model[ins[24:20]];
        ok = 1'b0;
        to_fp = 1'b0;
        v = '0;
        case (ins[6:0])
            OPC_OP: begin
                ok = 1'b1;
                if (f7 == 7'h00 && f3 == 3'd0) v = a + b;
                else if (f7 == 7'h20 && f3 == 3'd0) v = a - b;
                else if (f7 == 7'h00 && f3 == 3'd4) v = a ^ b;
                else if (f7 == 7'h00 && f3 == 3'd6) v = a | b;
                else if (f7 == 7'h00 && f3 == 3'd7) v = a & b;
                else ok = 1'b0;
            end
            OPC_IMM: begin
                ok = (f3 == 3'd0);
                v  = a + {{20{ins[31]}}, ins[31:20]};  // ADDI.
            end
            OPC_FP: begin
                if (f7 == 7'h10 && f3 <= 3'd2) begin
                    ok = 1'b1;
                    to_fp = 1'b1;
                    v[30:0] = fa[30:0];  // Magnitude from rs1.
                    v[31] = (f3 == 3'd0) ? fb[31] : (f3 == 3'd1) ? ~fb[31] : fa[31] ^ fb[31];
                end else if (f7 == 7'h70 && f3 == 3'd0) begin
                    ok = 1'b1;
                    v  = fa;              // FMV.X.W.
                end else if (f7 == 7'h78 && f3 == 3'd0) begin
                    ok = 1'b1;
                    to_fp = 1'b1;
                    v  = a;               // FMV.W.X.
                end
            end
            default: ;
        endcase
        if (ok && to_fp) fp_model[rd] = v;
        else if (ok && rd != 5'd0) int_model[rd] = v;
        res = {to_fp, rd, v};
        return ok;
    endfunction

    // ################################################
    // Encoders and stimulus.
    // ################################################

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
        input logic [11:0] imm);
        return {imm, rs1, 3'd0, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] random_alu(input logic [4:0] rd, input logic [4:0] rs1,
        input logic [4:0] rs2);
        case (rand_word() % 6)
            0: return r_type(7'h00, rs2, rs1, 3'd0, rd, OPC_OP);  // ADD.
            1: return r_type(7'h20, rs2, rs1, 3'd0, rd, OPC_OP);  // SUB.
            2: return r_type(7'h00, rs2, rs1, 3'd7, rd, OPC_OP);
            3: return r_type(7'h00, rs2, rs1, 3'd6, rd, OPC_OP);
            4: return r_type(7'h00, rs2, rs1, 3'd4, rd, OPC_OP);
            default: return addi_word(rd, rs1, rand_word());
        endcase
    endfunction

    function automatic logic [31:0] random_sgnj(input logic [4:0] rd, input logic [4:0] rs1,
        input logic [4:0] rs2);
        return r_type(7'h10, rs2, rs1, 3'(rand_word() % 3), rd, OPC_FP);
    endfunction

    task automatic send(input logic [31:0] ins);
        logic [37:0] r;
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= ins;
        if (ref_exec(ins, r)) begin
            exp_q.push_back(r);
            supported_sent++;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        instr_i       <= rand_word();  // Garbage while invalid.
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %h, actual %h", current_test, what, exp, act);
            error_count++;
            test_errors++;
        end
    endtask

    // Idle until every expected result is back or the wait runs out.
    task automatic drain();
        int wait_cycles;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 40) begin
            idle_cycle();
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout in %s: %0d expected results never came out", current_test,
                     exp_q.size());
            error_count++;
            test_errors++;
            exp_q.delete();
        end
        repeat (3) idle_cycle();  // Catch stray results.
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic end_test();
        drain();
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("%-22s %s (%0d errors)", current_test, test_errors ? "FAIL" : "ok", test_errors);
    endtask

    // ################################################
    // Compare process.
    // ################################################

    always @(negedge clk_i) begin
        logic [37:0] e;
        if (result_valid_o === 1'b1) begin
            results_seen++;
            if (exp_q.size() == 0) begin
                $display("Unexpected result in %s: rd %0d with nothing outstanding",
                         current_test, result_rd_o);
                error_count++;
                test_errors++;
            end else begin
                e = exp_q.pop_front();
                check_value("rd", 32'(e[36:32]), 32'(result_rd_o));
                check_value("float class", 32'(e[37]), 32'(result_is_float_o));
                check_value("data", e[31:0], result_data_o);
            end
        end
    end

    // ################################################
    // Tests.
    // ################################################

    initial begin
        int i, d, k, n, sent_before, seen_before;
        logic [4:0] r;
        clk_i = 1'b0;
        rst_i = 1'b1;
        instr_valid_i = 1'b0;
        instr_i = '0;
        for (i = 0; i < 32; i++) begin
            int_model[i] = '0;
            fp_model[i]  = '0;
        end
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;

        start_test("reset_and_init");
        repeat (6) begin
            @(negedge clk_i);
            check_value("valid after reset", 32'd0, 32'(result_valid_o));
        end
        for (i = 1; i < 32; i++) send(addi_word(i, 0, rand_word()));
        for (i = 0; i < 32; i++) send(r_type(7'h78, 0, (i * 7) % 31 + 1, 0, i, OPC_FP));
        for (i = 1; i < 32; i++) send(r_type(7'h00, 0, i, 0, i, OPC_OP));  // ADD xi, xi, x0.
        for (i = 0; i < 32; i++) send(r_type(7'h70, 0, i, 0, 0, OPC_FP));  // FMV.X.W x0, fi.
        end_test();

        start_test("integer_alu");
        repeat (60) send(random_alu(16 + rand_word() % 16, rand_word() % 16, rand_word() % 16));
        send(addi_word(0, 5, rand_word()));               // x0 as destination.
        send(r_type(7'h00, 0, 0, 0, 7, OPC_OP));          // Still reads zero.
        send(r_type(7'h00, 3, 0, 0, 8, OPC_OP));
        end_test();

        start_test("dependency_chains");
        for (d = 1; d <= 3; d++) begin
            for (i = 0; i < 12; i++) begin
                r = 20 + i % d;                           // Reads its own result d back.
                send(random_alu(r, r, rand_word() % 8));
            end
            for (i = 0; i < 12; i++) begin
                r = 8 + i % d;
                send(random_sgnj(r, r, rand_word() % 32));
            end
        end
        end_test();

        start_test("sign_injection_moves");
        for (i = 1; i <= 8; i++) begin
            send(addi_word(i, 0, rand_word()));           // Random sign.
            send(r_type(7'h78, 0, i, 0, rand_word() % 32, OPC_FP));
        end
        repeat (40) send(random_sgnj(rand_word() % 32, rand_word() % 32, rand_word() % 32));
        send(random_sgnj(3, 0, 0));                       // f0 on both sources.
        send(r_type(7'h70, 0, 0, 0, 9, OPC_FP));
        repeat (10) begin
            n = rand_word() % 32;
            send(r_type(7'h78, 0, 1 + rand_word() % 31, 0, n, OPC_FP));
            send(r_type(7'h70, 0, n, 0, 1 + rand_word() % 31, OPC_FP));  // Round trip.
        end
        end_test();

        start_test("separate_banks");
        repeat (10) begin
            n = 1 + rand_word() % 31;
            k = (n + 7) % 31 + 1;
            send(addi_word(n, 0, rand_word()));
            send(r_type(7'h78, 0, k, 0, n, OPC_FP));      // fN from a different value.
            send(random_sgnj(k, n, n));
            send(r_type(7'h00, 0, n, 0, k, OPC_OP));      // wb holds fN and must not hit.
            send(r_type(7'h78, 0, k, 0, n, OPC_FP));
            send(addi_word(n, 0, rand_word()));
            send(r_type(7'h70, 0, n, 0, k, OPC_FP));      // ex holds xN, wb holds fN.
        end
        end_test();

        start_test("unsupported_and_gaps");
        sent_before = supported_sent;
        seen_before = results_seen;
        for (i = 0; i < 80; i++) begin
            k = rand_word() % 9;
            case (k)
                0, 1, 2, 3: send(random_alu(rand_word(), rand_word(), rand_word()));
                4: send(random_sgnj(rand_word(), rand_word(), rand_word()));
                5: idle_cycle();
                6: send({12'(rand_word() >> 20), 5'd1, 3'd2, 5'd4, 7'h03});  // LW.
                7: send(r_type(7'h00, 2, 3, 3'd1, 4, OPC_OP));              // SLL.
                default: send(r_type(7'h00, 2, 3, 3'd0, 4, OPC_FP));        // FADD.S.
            endcase
        end
        drain();
        check_value("result count", supported_sent - sent_before, results_seen - seen_before);
        end_test();

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_apogeo_datapath
